/* hw/clock_pkg.sv */
// Time field types and default divider lengths; the defaults assume a 50 MHz clk
package clock_pkg;

	// ------------------------------
	// Time field widths
	// ------------------------------
	// Seconds or minutes, 0..59
	typedef logic [5:0] sec_t;
	// Hours, 0..23
	typedef logic [4:0] hour_t;

	localparam sec_t  SEC_MAX  = 6'd59;
	localparam hour_t HOUR_MAX = 5'd23;

	// ------------------------------
	// Control state
	// ------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_e;

	typedef enum logic [1:0] {
		FIELD_SEC  = 2'd0,
		FIELD_MIN  = 2'd1,
		FIELD_HOUR = 2'd2
	} field_e;

	// Divider lengths in clk cycles
	localparam int CYCLES_PER_SEC_DEF    = 32'd50_000_000;
	localparam int CYCLES_PER_SCAN_DEF   = 32'd5_000;
	localparam int CYCLES_PER_SAMPLE_DEF = 32'd500_000;

endpackage

/* hw/display_pkg.sv */
// Display types and patterns; segments are active high and ordered a..g from the MSB
package display_pkg;

	localparam int DIGITS = 6;

	// One decimal digit
	typedef logic [3:0] bcd_t;
	// Segments {a, b, c, d, e, f, g}
	typedef logic [6:0] seg_t;
	// One-cold digit enable, bit 0 is the seconds ones digit
	typedef logic [DIGITS-1:0] digit_sel_t;

	// ------------------------------
	// Segment patterns
	// ------------------------------
	localparam seg_t SEG_BLANK = 7'b000_0000;
	localparam seg_t SEG_0     = 7'b111_1110;
	localparam seg_t SEG_1     = 7'b011_0000;
	localparam seg_t SEG_2     = 7'b110_1101;
	localparam seg_t SEG_3     = 7'b111_1001;
	localparam seg_t SEG_4     = 7'b011_0011;
	localparam seg_t SEG_5     = 7'b101_1011;
	localparam seg_t SEG_6     = 7'b101_1111;
	localparam seg_t SEG_7     = 7'b111_0000;
	localparam seg_t SEG_8     = 7'b111_1111;
	localparam seg_t SEG_9     = 7'b111_0011;

endpackage

/* hw/tick_gen.sv */
// One-cycle strobe every CYCLES clk cycles; CYCLES must be at least 1, first strobe N cycles after reset
`timescale 1ns/100ps

module tick_gen #(
	parameter int CYCLES = 1
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int CNT_W = (CYCLES > 1) ? $clog2(CYCLES) : 1;

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else begin
			// Strobe registered at the top of the count
			o_tick <= (cnt == CNT_W'(CYCLES - 1));
			if (cnt == CNT_W'(CYCLES - 1)) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	a_tick_single: assert property (@(posedge clk) disable iff (!rst_n)
		(CYCLES > 1 && o_tick) |=> !o_tick);

endmodule

/* hw/key_filter.sv */
// Press detector for one active-low key; the key must stay low across a sample strobe to count
`timescale 1ns/100ps

module key_filter (
	input  logic clk,
	input  logic rst_n,
	input  logic i_sample,
	input  logic i_key_n,
	output logic o_press
);

	// Newest and previous sampled levels, high is released
	logic key_now;
	logic key_prev;
	logic sample_d;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			key_now  <= 1'b1;
			key_prev <= 1'b1;
			sample_d <= 1'b0;
		end else begin
			sample_d <= i_sample;
			if (i_sample) begin
				key_prev <= key_now;
				key_now  <= i_key_n;
			end
		end
	end

	// High to low across the last two samples, once per strobe
	assign o_press = sample_d & key_prev & ~key_now;

endmodule

/* hw/clock_ctrl.sv */
// Mode, field and alarm enable from press pulses; a mode press beats a field press in the same cycle
`timescale 1ns/100ps

module clock_ctrl (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_mode_press,
	input  logic               i_field_press,
	input  logic               i_alarm_press,
	output clock_pkg::mode_e   o_mode,
	output clock_pkg::field_e  o_field,
	output logic               o_alarm_en
);

	clock_pkg::mode_e  mode_next;
	clock_pkg::field_e field_next;

	// ------------------------------
	// Step order
	// ------------------------------
	always_comb begin
		case (o_mode)
			clock_pkg::MODE_CLOCK: mode_next = clock_pkg::MODE_SETUP;
			clock_pkg::MODE_SETUP: mode_next = clock_pkg::MODE_ALARM;
			default:               mode_next = clock_pkg::MODE_CLOCK;
		endcase
	end

	always_comb begin
		case (o_field)
			clock_pkg::FIELD_SEC: field_next = clock_pkg::FIELD_MIN;
			clock_pkg::FIELD_MIN: field_next = clock_pkg::FIELD_HOUR;
			default:              field_next = clock_pkg::FIELD_SEC;
		endcase
	end

	// ------------------------------
	// State registers
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode  <= clock_pkg::MODE_CLOCK;
			o_field <= clock_pkg::FIELD_SEC;
		end else if (i_mode_press) begin
			o_mode  <= mode_next;
			// Every new mode starts on the seconds field
			o_field <= clock_pkg::FIELD_SEC;
		end else if (i_field_press) begin
			o_field <= field_next;
		end
	end

	// Alarm key is independent of the mode
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm_en <= 1'b0;
		end else if (i_alarm_press) begin
			o_alarm_en <= ~o_alarm_en;
		end
	end

	a_mode_legal: assert property (@(posedge clk) disable iff (!rst_n)
		o_mode inside {clock_pkg::MODE_CLOCK, clock_pkg::MODE_SETUP, clock_pkg::MODE_ALARM});

endmodule

/* hw/time_keeper.sv */
// Running and alarm time; setup stops counting, and increments wrap one field without carry
`timescale 1ns/100ps

module time_keeper (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_sec_tick,
	input  logic               i_inc,
	input  clock_pkg::mode_e   i_mode,
	input  clock_pkg::field_e  i_field,
	input  logic               i_alarm_en,
	output clock_pkg::sec_t    o_sec,
	output clock_pkg::sec_t    o_min,
	output clock_pkg::hour_t   o_hour,
	output logic               o_alarm
);

	clock_pkg::sec_t  sec;
	clock_pkg::sec_t  min;
	clock_pkg::hour_t hour;
	clock_pkg::sec_t  al_sec;
	clock_pkg::sec_t  al_min;
	clock_pkg::hour_t al_hour;
	logic             match;

	function automatic clock_pkg::sec_t inc_sec(input clock_pkg::sec_t v);
		return (v == clock_pkg::SEC_MAX) ? '0 : v + 1'b1;
	endfunction

	function automatic clock_pkg::hour_t inc_hour(input clock_pkg::hour_t v);
		return (v == clock_pkg::HOUR_MAX) ? '0 : v + 1'b1;
	endfunction

	// ------------------------------
	// Running time
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sec  <= '0;
			min  <= '0;
			hour <= '0;
		end else if (i_mode == clock_pkg::MODE_SETUP) begin
			if (i_inc) begin
				case (i_field)
					clock_pkg::FIELD_SEC: sec  <= inc_sec(sec);
					clock_pkg::FIELD_MIN: min  <= inc_sec(min);
					default:              hour <= inc_hour(hour);
				endcase
			end
		end else if (i_sec_tick) begin
			sec <= inc_sec(sec);
			// Carry chain on the same edge
			if (sec == clock_pkg::SEC_MAX) begin
				min <= inc_sec(min);
				if (min == clock_pkg::SEC_MAX) begin
					hour <= inc_hour(hour);
				end
			end
		end
	end

	// ------------------------------
	// Alarm time
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			al_sec  <= '0;
			al_min  <= '0;
			al_hour <= '0;
		end else if (i_mode == clock_pkg::MODE_ALARM && i_inc) begin
			case (i_field)
				clock_pkg::FIELD_SEC: al_sec  <= inc_sec(al_sec);
				clock_pkg::FIELD_MIN: al_min  <= inc_sec(al_min);
				default:              al_hour <= inc_hour(al_hour);
			endcase
		end
	end

	assign match = (sec == al_sec) && (min == al_min) && (hour == al_hour);

	// Latched until the alarm is disabled
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else begin
			o_alarm <= i_alarm_en & (o_alarm | match);
		end
	end

	// Alarm mode shows the alarm setting
	assign o_sec  = (i_mode == clock_pkg::MODE_ALARM) ? al_sec  : sec;
	assign o_min  = (i_mode == clock_pkg::MODE_ALARM) ? al_min  : min;
	assign o_hour = (i_mode == clock_pkg::MODE_ALARM) ? al_hour : hour;

	a_field_range: assert property (@(posedge clk) disable iff (!rst_n)
		sec <= clock_pkg::SEC_MAX && min <= clock_pkg::SEC_MAX
		&& hour <= clock_pkg::HOUR_MAX && al_sec <= clock_pkg::SEC_MAX
		&& al_min <= clock_pkg::SEC_MAX && al_hour <= clock_pkg::HOUR_MAX);

endmodule

/* hw/seg_scan.sv */
// Six-digit scan, one digit per scan strobe; o_seg_enb is active low and o_seg is active high
`timescale 1ns/100ps

module seg_scan (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    i_scan_tick,
	input  clock_pkg::sec_t         i_sec,
	input  clock_pkg::sec_t         i_min,
	input  clock_pkg::hour_t        i_hour,
	input  clock_pkg::mode_e        i_mode,
	output display_pkg::seg_t       o_seg,
	output logic                    o_seg_dp,
	output display_pkg::digit_sel_t o_seg_enb
);

	logic [2:0]        slot;
	clock_pkg::sec_t   value;
	display_pkg::bcd_t digit;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			slot <= '0;
		end else if (i_scan_tick) begin
			slot <= (slot == 3'(display_pkg::DIGITS - 1)) ? 3'd0 : slot + 1'b1;
		end
	end

	// ------------------------------
	// Slot to digit
	// ------------------------------
	// Pairs of slots share one field, odd slot is the tens digit
	always_comb begin
		case (slot)
			3'd0, 3'd1: value = i_sec;
			3'd2, 3'd3: value = i_min;
			default:    value = {1'b0, i_hour};
		endcase
		digit = slot[0] ? display_pkg::bcd_t'(value / 6'd10)
		                : display_pkg::bcd_t'(value % 6'd10);
	end

	always_comb begin
		case (digit)
			4'd0:    o_seg = display_pkg::SEG_0;
			4'd1:    o_seg = display_pkg::SEG_1;
			4'd2:    o_seg = display_pkg::SEG_2;
			4'd3:    o_seg = display_pkg::SEG_3;
			4'd4:    o_seg = display_pkg::SEG_4;
			4'd5:    o_seg = display_pkg::SEG_5;
			4'd6:    o_seg = display_pkg::SEG_6;
			4'd7:    o_seg = display_pkg::SEG_7;
			4'd8:    o_seg = display_pkg::SEG_8;
			4'd9:    o_seg = display_pkg::SEG_9;
			default: o_seg = display_pkg::SEG_BLANK;
		endcase
	end

	assign o_seg_enb = ~(display_pkg::digit_sel_t'(1) << slot);

	// Mode marker dots
	assign o_seg_dp = (slot == 3'd0 && i_mode == clock_pkg::MODE_SETUP)
	               || (slot == 3'd1 && i_mode == clock_pkg::MODE_ALARM);

	a_enb_one_cold: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~o_seg_enb));

endmodule

/* hw/clock_top.sv */
// Clock top level; keys are active low and assumed already in the clk domain
`timescale 1ns/100ps

module clock_top #(
	parameter int CYCLES_PER_SEC    = clock_pkg::CYCLES_PER_SEC_DEF,
	parameter int CYCLES_PER_SCAN   = clock_pkg::CYCLES_PER_SCAN_DEF,
	parameter int CYCLES_PER_SAMPLE = clock_pkg::CYCLES_PER_SAMPLE_DEF
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    i_key_mode_n,
	input  logic                    i_key_field_n,
	input  logic                    i_key_inc_n,
	input  logic                    i_key_alarm_n,
	output display_pkg::seg_t       o_seg,
	output logic                    o_seg_dp,
	output display_pkg::digit_sel_t o_seg_enb,
	output logic                    o_alarm
);

	logic sec_tick, scan_tick, sample_tick;
	logic mode_press, field_press, inc_press, alarm_press;
	logic alarm_en;
	clock_pkg::mode_e  mode;
	clock_pkg::field_e field;
	clock_pkg::sec_t   show_sec, show_min;
	clock_pkg::hour_t  show_hour;

	// ------------------------------
	// Dividers
	// ------------------------------
	tick_gen #(.CYCLES(CYCLES_PER_SEC)) sec_div_i (.clk, .rst_n, .o_tick(sec_tick));
	tick_gen #(.CYCLES(CYCLES_PER_SCAN)) scan_div_i (.clk, .rst_n, .o_tick(scan_tick));
	tick_gen #(.CYCLES(CYCLES_PER_SAMPLE)) sample_div_i (.clk, .rst_n, .o_tick(sample_tick));

	// Keys
	key_filter mode_key_i (.clk, .rst_n, .i_sample(sample_tick),
		.i_key_n(i_key_mode_n), .o_press(mode_press));
	key_filter field_key_i (.clk, .rst_n, .i_sample(sample_tick),
		.i_key_n(i_key_field_n), .o_press(field_press));
	key_filter inc_key_i (.clk, .rst_n, .i_sample(sample_tick),
		.i_key_n(i_key_inc_n), .o_press(inc_press));
	key_filter alarm_key_i (.clk, .rst_n, .i_sample(sample_tick),
		.i_key_n(i_key_alarm_n), .o_press(alarm_press));

	clock_ctrl ctrl_i (.clk, .rst_n, .i_mode_press(mode_press), .i_field_press(field_press),
		.i_alarm_press(alarm_press), .o_mode(mode), .o_field(field), .o_alarm_en(alarm_en));

	time_keeper time_i (.clk, .rst_n, .i_sec_tick(sec_tick), .i_inc(inc_press),
		.i_mode(mode), .i_field(field), .i_alarm_en(alarm_en), .o_sec(show_sec),
		.o_min(show_min), .o_hour(show_hour), .o_alarm);

	seg_scan scan_i (.clk, .rst_n, .i_scan_tick(scan_tick), .i_sec(show_sec),
		.i_min(show_min), .i_hour(show_hour), .i_mode(mode), .o_seg, .o_seg_dp, .o_seg_enb);

endmodule

/* sim/clock_checker.sv */
// Cycle model of the clock; divider lengths must match the DUT, keys must change away from posedge
`timescale 1ns/100ps

module clock_checker #(
	parameter int SEC_N    = 40,
	parameter int SCAN_N   = 2,
	parameter int SAMPLE_N = 4
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    i_key_mode_n,
	input  logic                    i_key_field_n,
	input  logic                    i_key_inc_n,
	input  logic                    i_key_alarm_n,
	input  display_pkg::seg_t       i_seg,
	input  logic                    i_seg_dp,
	input  display_pkg::digit_sel_t i_seg_enb,
	input  logic                    i_alarm,
	output int                      o_errors,
	output int                      o_checks
);

	localparam int M_SETUP = 1;
	localparam int M_ALARM = 2;
	// Standard a..g patterns for 0..9, segment a in the MSB
	localparam logic [6:0] SEG_TABLE [10] = '{7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33,
		7'h5b, 7'h5f, 7'h70, 7'h7f, 7'h73};

	int cyc;
	int mode;
	int field;
	int slot;
	// Index 0 seconds, 1 minutes, 2 hours
	int t[3];
	int a[3];
	logic alarm_en;
	logic alarm;
	logic samp_d;
	logic [3:0] k_now;
	logic [3:0] k_prev;
	logic [3:0] keys_n;
	int errors = 0;
	int checks = 0;

	assign keys_n   = {i_key_alarm_n, i_key_inc_n, i_key_field_n, i_key_mode_n};
	assign o_errors = errors;
	assign o_checks = checks;

	function automatic int field_limit(input int f);
		return (f == 2) ? int'(clock_pkg::HOUR_MAX) + 1 : int'(clock_pkg::SEC_MAX) + 1;
	endfunction

	task automatic compare_value(input string name, input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			errors++;
			$display("mismatch %s at %0t: expected %0h, actual %0h", name, $time, expected, actual);
		end
	endtask

	// ------------------------------
	// Model state, one step per edge
	// ------------------------------
	always @(posedge clk or negedge rst_n) begin
		logic [3:0] press;
		logic sec_tk;
		logic scan_tk;
		logic samp_tk;
		logic match;
		if (!rst_n) begin
			cyc      = 0;
			mode     = 0;
			field    = 0;
			slot     = 0;
			t        = '{0, 0, 0};
			a        = '{0, 0, 0};
			alarm_en = 1'b0;
			alarm    = 1'b0;
			samp_d   = 1'b0;
			k_now    = '1;
			k_prev   = '1;
		end else begin
			// Strobes fire N cycles after release and every N after that
			sec_tk  = (cyc != 0) && (cyc % SEC_N == 0);
			scan_tk = (cyc != 0) && (cyc % SCAN_N == 0);
			samp_tk = (cyc != 0) && (cyc % SAMPLE_N == 0);
			press   = {4{samp_d}} & k_prev & ~k_now;
			match   = (t[0] == a[0]) && (t[1] == a[1]) && (t[2] == a[2]);
			alarm   = alarm_en && (alarm || match);
			if (mode == M_SETUP) begin
				if (press[2])
					t[field] = (t[field] + 1) % field_limit(field);
			end else if (sec_tk) begin
				t[0] = (t[0] + 1) % field_limit(0);
				if (t[0] == 0) begin
					t[1] = (t[1] + 1) % field_limit(1);
					if (t[1] == 0)
						t[2] = (t[2] + 1) % field_limit(2);
				end
			end
			if (mode == M_ALARM && press[2])
				a[field] = (a[field] + 1) % field_limit(field);
			if (press[0]) begin
				mode  = (mode + 1) % 3;
				field = 0;
			end else if (press[1]) begin
				field = (field + 1) % 3;
			end
			if (press[3])
				alarm_en = !alarm_en;
			samp_d = samp_tk;
			if (samp_tk) begin
				k_prev = k_now;
				k_now  = keys_n;
			end
			if (scan_tk)
				slot = (slot + 1) % display_pkg::DIGITS;
			cyc++;
		end
	end

	// ------------------------------
	// Compare on the falling edge
	// ------------------------------
	always @(negedge clk) begin
		int shown;
		int digit;
		int dot_slot;
		display_pkg::digit_sel_t exp_enb;
		logic exp_dp;
		if (rst_n) begin
			shown   = (mode == M_ALARM) ? a[slot / 2] : t[slot / 2];
			// Odd slots carry the tens digit
			digit   = (slot % 2 == 1) ? shown / 10 : shown % 10;
			// Only the current slot is enabled, low
			for (int i = 0; i < display_pkg::DIGITS; i++)
				exp_enb[i] = (i != slot);
			// Setup marks the seconds ones digit, alarm the seconds tens digit
			case (mode)
				M_SETUP: dot_slot = 0;
				M_ALARM: dot_slot = 1;
				default: dot_slot = -1;
			endcase
			exp_dp  = (slot == dot_slot);
			compare_value("alarm output", int'(alarm), int'(i_alarm));
			compare_value("digit enable", int'(exp_enb), int'(i_seg_enb));
			compare_value("segments", int'(SEG_TABLE[digit]), int'(i_seg));
			compare_value("mode dot", int'(exp_dp), int'(i_seg_dp));
			if (!$onehot(~i_seg_enb)) begin
				errors++;
				$display("Error at %0t: more or less than one digit is enabled", $time);
			end
		end
	end

endmodule

/* sim/tb_clock.sv */
// Testbench for the clock top with short dividers; random key presses from a fixed seed
`timescale 1ns/100ps

module tb_clock;

	localparam int SEC_N       = 40;
	localparam int SCAN_N      = 2;
	localparam int SAMPLE_N    = 4;
	localparam int PERIOD      = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int PRESSES     = 200;
	localparam int HOLD        = 3 * SAMPLE_N;
	localparam int IDLE_MAX    = 64;
	// Long enough for the seconds to wrap into the minutes
	localparam int WRAP_CYCLES = 62 * SEC_N;
	localparam int LIMIT_CYCLES = 4 + 4 * HOLD + WRAP_CYCLES
		+ PRESSES * (2 * HOLD + IDLE_MAX + 1) + 4 * SCAN_N * display_pkg::DIGITS + 100;
	localparam int KEY_ALARM   = 3;

	logic clk;
	logic rst_n;
	// Bit 0 mode, 1 field, 2 inc, 3 alarm
	logic [3:0] keys_n;
	display_pkg::seg_t       seg;
	logic                    seg_dp;
	display_pkg::digit_sel_t seg_enb;
	logic                    alarm;
	int errors;
	int checks;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	clock_top #(.CYCLES_PER_SEC(SEC_N), .CYCLES_PER_SCAN(SCAN_N),
		.CYCLES_PER_SAMPLE(SAMPLE_N)) clock_top_i (.clk, .rst_n,
		.i_key_mode_n(keys_n[0]), .i_key_field_n(keys_n[1]), .i_key_inc_n(keys_n[2]),
		.i_key_alarm_n(keys_n[3]), .o_seg(seg), .o_seg_dp(seg_dp), .o_seg_enb(seg_enb),
		.o_alarm(alarm));

	clock_checker #(.SEC_N(SEC_N), .SCAN_N(SCAN_N), .SAMPLE_N(SAMPLE_N)) checker_i (
		.clk, .rst_n, .i_key_mode_n(keys_n[0]), .i_key_field_n(keys_n[1]),
		.i_key_inc_n(keys_n[2]), .i_key_alarm_n(keys_n[3]), .i_seg(seg), .i_seg_dp(seg_dp),
		.i_seg_enb(seg_enb), .i_alarm(alarm), .o_errors(errors), .o_checks(checks));

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#DRIVE_DELAY;
	endtask

	// Low for three sample periods, then high for three
	task automatic press_key(input int idx);
		keys_n[idx] = 1'b0;
		wait_cycles(HOLD);
		keys_n[idx] = 1'b1;
		wait_cycles(HOLD);
	endtask

	// ------------------------------
	// Stimulus
	// ------------------------------
	initial begin
		void'($urandom(32'h7d2e));
		keys_n = 4'hf;
		rst_n  = 1'b0;
		wait_cycles(4);
		rst_n = 1'b1;
		// Enable while time and alarm time are both zero
		press_key(KEY_ALARM);
		wait_cycles(WRAP_CYCLES);
		press_key(KEY_ALARM);
		for (int i = 0; i < PRESSES; i++) begin
			press_key($urandom % 4);
			wait_cycles(1 + $urandom % IDLE_MAX);
		end
		wait_cycles(2 * SCAN_N * display_pkg::DIGITS);
		$display("Checks done: %0d compared, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(LIMIT_CYCLES * PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* compile.f */
hw/clock_pkg.sv
hw/display_pkg.sv
hw/tick_gen.sv
hw/key_filter.sv
hw/clock_ctrl.sv
hw/time_keeper.sv
hw/seg_scan.sv
hw/clock_top.sv
sim/clock_checker.sv
sim/tb_clock.sv

/* Makefile */
# Verilator build and run of the clock testbench
VERILATOR ?= verilator
TOP       ?= tb_clock
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and search the output for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
